/* src/eth_dma_pkg.sv */
package eth_dma_pkg;

  // One word of the descriptor memory
  typedef logic [31:0] bd_word_t;

  // Frame data as seen by the transmit buffer and the AXI read channel
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] axi_data_t;

  // Byte count handed to the transmitter, header included
  typedef logic [10:0] nbytes_t;

  // Length field of the control/status word
  typedef logic [15:0] frame_len_t;

  // AXI burst length, beats minus one
  typedef logic [7:0]  burst_len_t;

  // Preamble and start-of-frame delimiter
  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hD5;
  localparam int    PREAMBLE_LEN  = 7;

  // Frame data starts after preamble and SFD
  localparam int    HEADER_LEN    = PREAMBLE_LEN + 1;

  // Single-byte beats per burst at most
  localparam int    MAX_BURST_LEN = 16;

  // Control/status word fields
  localparam int    BD_READY_BIT  = 15;
  localparam int    BD_IRQ_BIT    = 14;
  localparam int    BD_WRAP_BIT   = 13;
  localparam int    BD_CRC_BIT    = 11;
  localparam int    BD_LEN_LSB    = 16;

endpackage

/* src/tx_dma_if.sv */
`timescale 1ns/1ps

interface tx_dma_if #(
  parameter int AXI_ADDR_W = 32,
  parameter int BD_ADDR_W  = 8
);

  // Descriptor currently in flight
  eth_dma_pkg::bd_word_t bd_word;
  logic [AXI_ADDR_W-1:0] frame_ptr;
  logic [BD_ADDR_W-2:0]  bd_num;

  // Decode to execute, single cycle
  logic copy_start;
  // Execute to result, single cycle
  logic copy_done;
  // Result to decode, level held until wb_done
  logic wb_req;
  logic wb_done;

  modport fetch_mp (
    output bd_word, frame_ptr, bd_num, copy_start, wb_done,
    input  wb_req
  );

  modport copy_mp (
    input  bd_word, frame_ptr, copy_start,
    output copy_done
  );

  modport launch_mp (
    input  bd_word, copy_done, wb_done,
    output wb_req
  );

endinterface

/* src/tx_bd_fetch.sv */
`timescale 1ns/1ps

module tx_bd_fetch #(
  parameter int AXI_ADDR_W = 32,
  parameter int BD_ADDR_W  = 8
) (
  input  logic                  clk_i,
  input  logic                  arst_i,
  input  logic                  tx_en_i,
  input  logic                  tx_ready_i,
  input  logic                  hdr_done_i,
  input  eth_dma_pkg::bd_word_t bd_i,
  output logic [BD_ADDR_W-1:0]  bd_addr_o,
  output logic                  bd_wen_o,
  output eth_dma_pkg::bd_word_t bd_o,
  output logic                  tx_irq_o,
  tx_dma_if.fetch_mp            dma
);

  typedef enum logic [2:0] {
    S_FETCH,
    S_PTR,
    S_WAIT,
    S_BUSY,
    S_WB
  } fetch_state_t;

  fetch_state_t state;
  // Set on the cycle where bd_i holds the word addressed one cycle earlier
  logic         rd_phase;
  logic         bd_go;
  logic         bd_wrap;

  assign bd_go   = bd_i[eth_dma_pkg::BD_READY_BIT] && tx_en_i;
  assign bd_wrap = dma.bd_word[eth_dma_pkg::BD_WRAP_BIT] || (&dma.bd_num);

  // Word 2n for status, word 2n+1 for the frame pointer
  assign bd_addr_o = {dma.bd_num, (state == S_PTR)};

  // Status writeback takes a single cycle
  assign bd_wen_o    = (state == S_WB);
  assign dma.wb_done = (state == S_WB);
  assign tx_irq_o    = (state == S_WB) && dma.bd_word[eth_dma_pkg::BD_IRQ_BIT];

  assign dma.copy_start = (state == S_WAIT) && tx_ready_i;

  // Same status word with the ready bit handed back to software
  always_comb begin
    bd_o = dma.bd_word;
    bd_o[eth_dma_pkg::BD_READY_BIT] = 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      state      <= S_FETCH;
      rd_phase   <= 1'b0;
      dma.bd_num <= '0;
    end else begin
      case (state)
        S_FETCH: begin
          // Header must be in the buffer before the first frame
          if (rd_phase) begin
            rd_phase <= 1'b0;
            if (bd_go) begin
              state <= S_PTR;
            end
          end else if (hdr_done_i) begin
            rd_phase <= 1'b1;
          end
        end
        S_PTR: begin
          rd_phase <= ~rd_phase;
          if (rd_phase) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (tx_ready_i) begin
            state <= S_BUSY;
          end
        end
        S_BUSY: begin
          if (dma.wb_req) begin
            state <= S_WB;
          end
        end
        S_WB: begin
          state <= S_FETCH;
          // Back to the ring start on wrap or at the last descriptor
          if (bd_wrap) begin
            dma.bd_num <= '0;
          end else begin
            dma.bd_num <= dma.bd_num + 1'b1;
          end
        end
        default: begin
          state <= S_FETCH;
        end
      endcase
    end
  end

  // Descriptor and pointer captures
  always_ff @(posedge clk_i) begin
    if ((state == S_FETCH) && rd_phase) begin
      dma.bd_word <= bd_i;
    end
    if ((state == S_PTR) && rd_phase) begin
      dma.frame_ptr <= AXI_ADDR_W'(bd_i);
    end
  end

endmodule

/* src/tx_frame_copy.sv */
`timescale 1ns/1ps

module tx_frame_copy #(
  parameter int AXI_ADDR_W = 32,
  parameter int BUFFER_W   = 11
) (
  input  logic                    clk_i,
  input  logic                    arst_i,
  output logic [AXI_ADDR_W-1:0]   araddr_o,
  output eth_dma_pkg::burst_len_t arlen_o,
  output logic                    arvalid_o,
  input  logic                    arready_i,
  input  eth_dma_pkg::axi_data_t  rdata_i,
  input  logic                    rvalid_i,
  input  logic                    rlast_i,
  output logic                    rready_o,
  output logic                    buf_wen_o,
  output logic [BUFFER_W-1:0]     buf_addr_o,
  output eth_dma_pkg::byte_t      buf_wdata_o,
  output logic                    hdr_done_o,
  tx_dma_if.copy_mp               dma
);

  typedef enum logic [1:0] {
    S_HDR,
    S_IDLE,
    S_ADDR,
    S_DATA
  } copy_state_t;

  copy_state_t             state;
  // Header bytes written, then frame bytes copied
  eth_dma_pkg::frame_len_t byte_cnt;
  eth_dma_pkg::frame_len_t frame_len;
  eth_dma_pkg::frame_len_t remaining;
  logic [AXI_ADDR_W-1:0]   cur_addr;
  logic [1:0]              lane;

  assign frame_len = dma.bd_word[eth_dma_pkg::BD_LEN_LSB +: $bits(eth_dma_pkg::frame_len_t)];
  assign remaining = frame_len - byte_cnt;
  assign cur_addr  = dma.frame_ptr + AXI_ADDR_W'(byte_cnt);

  // Narrow beats arrive on the lane of their byte address
  assign lane = cur_addr[1:0];

  // Address phase holds while the slave stalls
  assign araddr_o  = cur_addr;
  assign arvalid_o = (state == S_ADDR) && (remaining != '0);

  always_comb begin
    if (remaining > eth_dma_pkg::frame_len_t'(eth_dma_pkg::MAX_BURST_LEN)) begin
      arlen_o = eth_dma_pkg::burst_len_t'(eth_dma_pkg::MAX_BURST_LEN - 1);
    end else begin
      arlen_o = eth_dma_pkg::burst_len_t'(remaining - 1'b1);
    end
  end

  assign rready_o   = (state == S_DATA);
  assign hdr_done_o = (state != S_HDR);

  // Nothing left to fetch, zero length lands here at once
  assign dma.copy_done = (state == S_ADDR) && (remaining == '0);

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      state    <= S_HDR;
      byte_cnt <= '0;
    end else begin
      case (state)
        S_HDR: begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == eth_dma_pkg::HEADER_LEN - 1) begin
            state    <= S_IDLE;
            byte_cnt <= '0;
          end
        end
        S_IDLE: begin
          if (dma.copy_start) begin
            state    <= S_ADDR;
            byte_cnt <= '0;
          end
        end
        S_ADDR: begin
          if (remaining == '0) begin
            state <= S_IDLE;
          end else if (arready_i) begin
            state <= S_DATA;
          end
        end
        S_DATA: begin
          // Gaps in rvalid_i simply stall the copy
          if (rvalid_i) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (rlast_i) begin
              state <= S_ADDR;
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Buffer write strobe, one byte per cycle
  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      buf_wen_o <= 1'b0;
    end else begin
      buf_wen_o <= (state == S_HDR) || ((state == S_DATA) && rvalid_i);
    end
  end

  // Buffer address and data
  always_ff @(posedge clk_i) begin
    if (state == S_HDR) begin
      buf_addr_o <= BUFFER_W'(byte_cnt);
      if (byte_cnt == eth_dma_pkg::PREAMBLE_LEN) begin
        buf_wdata_o <= eth_dma_pkg::SFD_BYTE;
      end else begin
        buf_wdata_o <= eth_dma_pkg::PREAMBLE_BYTE;
      end
    end else begin
      buf_addr_o  <= BUFFER_W'(eth_dma_pkg::HEADER_LEN) + BUFFER_W'(byte_cnt);
      buf_wdata_o <= rdata_i[{lane, 3'b000} +: 8];
    end
  end

endmodule

/* src/tx_frame_launch.sv */
`timescale 1ns/1ps

module tx_frame_launch (
  input  logic                 clk_i,
  input  logic                 arst_i,
  input  logic                 tx_ready_i,
  output logic                 send_o,
  output logic                 crc_en_o,
  output eth_dma_pkg::nbytes_t tx_nbytes_o,
  tx_dma_if.launch_mp          dma
);

  // Transmitter took the frame
  logic tx_taken;

  assign tx_taken = send_o && !tx_ready_i;

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      send_o     <= 1'b0;
      dma.wb_req <= 1'b0;
    end else begin
      // Send stays up until the transmitter goes busy
      if (dma.copy_done) begin
        send_o <= 1'b1;
      end else if (tx_taken) begin
        send_o <= 1'b0;
      end

      // Writeback request held until decode has written the status
      if (tx_taken) begin
        dma.wb_req <= 1'b1;
      end else if (dma.wb_done) begin
        dma.wb_req <= 1'b0;
      end
    end
  end

  // Frame settings latched as the copy finishes
  always_ff @(posedge clk_i) begin
    if (dma.copy_done) begin
      crc_en_o    <= dma.bd_word[eth_dma_pkg::BD_CRC_BIT];
      // Low 11 length bits cover the largest frame
      tx_nbytes_o <= eth_dma_pkg::nbytes_t'(eth_dma_pkg::HEADER_LEN)
                   + dma.bd_word[eth_dma_pkg::BD_LEN_LSB +: $bits(eth_dma_pkg::nbytes_t)];
    end
  end

endmodule

/* src/eth_tx_dma.sv */
`timescale 1ns/1ps

module eth_tx_dma #(
  parameter int AXI_ADDR_W = 32,
  parameter int BUFFER_W   = 11,
  parameter int BD_ADDR_W  = 8
) (
  input  logic                    clk_i,
  input  logic                    arst_i,

  // Control and interrupt
  input  logic                    tx_en_i,
  output logic                    tx_irq_o,

  // Descriptor memory
  output logic [BD_ADDR_W-1:0]    bd_addr_o,
  output logic                    bd_wen_o,
  output eth_dma_pkg::bd_word_t   bd_o,
  input  eth_dma_pkg::bd_word_t   bd_i,

  // AXI read address and data
  output logic [AXI_ADDR_W-1:0]   araddr_o,
  output eth_dma_pkg::burst_len_t arlen_o,
  output logic                    arvalid_o,
  input  logic                    arready_i,
  input  eth_dma_pkg::axi_data_t  rdata_i,
  input  logic                    rvalid_i,
  input  logic                    rlast_i,
  output logic                    rready_o,

  // Transmit buffer write port
  output logic                    buf_wen_o,
  output logic [BUFFER_W-1:0]     buf_addr_o,
  output eth_dma_pkg::byte_t      buf_wdata_o,

  // Transmitter
  input  logic                    tx_ready_i,
  output logic                    send_o,
  output logic                    crc_en_o,
  output eth_dma_pkg::nbytes_t    tx_nbytes_o
);

  logic hdr_done;

  tx_dma_if #(
    .AXI_ADDR_W(AXI_ADDR_W),
    .BD_ADDR_W (BD_ADDR_W)
  ) dma_if ();

  // Decode: descriptor walk and status writeback
  tx_bd_fetch #(
    .AXI_ADDR_W(AXI_ADDR_W),
    .BD_ADDR_W (BD_ADDR_W)
  ) u_fetch (
    .clk_i     (clk_i),
    .arst_i    (arst_i),
    .tx_en_i   (tx_en_i),
    .tx_ready_i(tx_ready_i),
    .hdr_done_i(hdr_done),
    .bd_i      (bd_i),
    .bd_addr_o (bd_addr_o),
    .bd_wen_o  (bd_wen_o),
    .bd_o      (bd_o),
    .tx_irq_o  (tx_irq_o),
    .dma       (dma_if.fetch_mp)
  );

  // Execute: header and frame copy
  tx_frame_copy #(
    .AXI_ADDR_W(AXI_ADDR_W),
    .BUFFER_W  (BUFFER_W)
  ) u_copy (
    .clk_i      (clk_i),
    .arst_i     (arst_i),
    .araddr_o   (araddr_o),
    .arlen_o    (arlen_o),
    .arvalid_o  (arvalid_o),
    .arready_i  (arready_i),
    .rdata_i    (rdata_i),
    .rvalid_i   (rvalid_i),
    .rlast_i    (rlast_i),
    .rready_o   (rready_o),
    .buf_wen_o  (buf_wen_o),
    .buf_addr_o (buf_addr_o),
    .buf_wdata_o(buf_wdata_o),
    .hdr_done_o (hdr_done),
    .dma        (dma_if.copy_mp)
  );

  // Result: hand-off to the transmitter
  tx_frame_launch u_launch (
    .clk_i      (clk_i),
    .arst_i     (arst_i),
    .tx_ready_i (tx_ready_i),
    .send_o     (send_o),
    .crc_en_o   (crc_en_o),
    .tx_nbytes_o(tx_nbytes_o),
    .dma        (dma_if.launch_mp)
  );

endmodule

/* verification/eth_tx_dma_sva.sv */
`timescale 1ns/1ps

module eth_tx_dma_sva #(
  parameter int AXI_ADDR_W = 32
) (
  input logic                    clk_i,
  input logic                    arst_i,
  input logic [AXI_ADDR_W-1:0]   araddr_o,
  input eth_dma_pkg::burst_len_t arlen_o,
  input logic                    arvalid_o,
  input logic                    arready_i,
  input logic                    send_o,
  input logic                    tx_ready_i,
  input logic                    tx_irq_o,
  input logic                    bd_wen_o
);

  // Number of failed assertions
  int fail_cnt = 0;

  // Address phase stays put until the slave takes it
  property ar_hold_p;
    @(posedge clk_i) disable iff (arst_i)
      arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arlen_o);
  endproperty
  ar_hold_a: assert property (ar_hold_p)
    else begin
      fail_cnt++;
      $error("AXI read address changed before arready_i");
    end

  // Frame is offered until the transmitter goes busy
  property send_hold_p;
    @(posedge clk_i) disable iff (arst_i)
      send_o && tx_ready_i |=> send_o;
  endproperty
  send_hold_a: assert property (send_hold_p)
    else begin
      fail_cnt++;
      $error("send_o dropped while tx_ready_i was still high");
    end

  irq_with_wb_a: assert property (@(posedge clk_i) disable iff (arst_i) tx_irq_o |-> bd_wen_o)
    else begin
      fail_cnt++;
      $error("tx_irq_o pulsed without a status writeback");
    end

  // One descriptor in flight, so no burst during writeback
  wb_ar_excl_a: assert property (@(posedge clk_i) disable iff (arst_i) !(bd_wen_o && arvalid_o))
    else begin
      fail_cnt++;
      $error("bd_wen_o and arvalid_o high in the same cycle");
    end

endmodule

bind eth_tx_dma eth_tx_dma_sva #(
  .AXI_ADDR_W(AXI_ADDR_W)
) sva_i (
  .clk_i     (clk_i),
  .arst_i    (arst_i),
  .araddr_o  (araddr_o),
  .arlen_o   (arlen_o),
  .arvalid_o (arvalid_o),
  .arready_i (arready_i),
  .send_o    (send_o),
  .tx_ready_i(tx_ready_i),
  .tx_irq_o  (tx_irq_o),
  .bd_wen_o  (bd_wen_o)
);

/* verification/eth_tx_dma_tb.sv */
`timescale 1ns/1ps

module eth_tx_dma_tb;

  localparam int NUM_BD      = 30;
  localparam int MAX_LEN     = 40;
  localparam int BD_LAST     = 127;
  localparam int TX_OFF_BD   = 12;
  localparam int WATCHDOG_NS = NUM_BD * (MAX_LEN * 8 + 200) * 4;

  logic                    clk_i;
  logic                    arst_i;
  logic                    tx_en_i;
  logic                    tx_irq_o;
  logic [7:0]              bd_addr_o;
  logic                    bd_wen_o;
  eth_dma_pkg::bd_word_t   bd_o;
  eth_dma_pkg::bd_word_t   bd_i;
  logic [31:0]             araddr_o;
  eth_dma_pkg::burst_len_t arlen_o;
  logic                    arvalid_o;
  logic                    arready_i;
  eth_dma_pkg::axi_data_t  rdata_i;
  logic                    rvalid_i;
  logic                    rlast_i;
  logic                    rready_o;
  logic                    buf_wen_o;
  logic [10:0]             buf_addr_o;
  eth_dma_pkg::byte_t      buf_wdata_o;
  logic                    tx_ready_i;
  logic                    send_o;
  logic                    crc_en_o;
  eth_dma_pkg::nbytes_t    tx_nbytes_o;

  // Descriptor memory, captured transmit buffer and the prepared ring
  eth_dma_pkg::bd_word_t desc_mem [256];
  eth_dma_pkg::byte_t    tx_buf [2048];
  eth_dma_pkg::bd_word_t ctrl [NUM_BD];
  logic [31:0]           ptr [NUM_BD];

  integer seed     = 58;
  int     errors   = 0;
  int     checks   = 0;
  // Predicted frame in flight
  int     cur_n    = 0;
  int     issued   = 0;
  bit     sent     = 1'b0;
  int     wb_count = 0;
  // DMA must stay quiet while set
  bit     hold     = 1'b0;

  // Falling-edge samples used by the input drivers
  logic [7:0]  bd_addr_s = '0;
  logic [31:0] araddr_s  = '0;
  int          arlen_s   = 0;
  bit          ar_acc    = 1'b0;
  bit          r_acc     = 1'b0;
  bit          send_s    = 1'b0;
  logic [31:0] beat_addr = '0;
  int          beats_left = 0;
  int          tx_phase  = 0;
  int          tx_cnt    = 0;

  eth_tx_dma DUT (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // External memory contents, every address bit matters
  function automatic eth_dma_pkg::byte_t ext_byte(input logic [31:0] a);
    return a[7:0] ^ {a[12:8], a[15:13]} ^ {a[19:16], a[23:20]} ^ ~a[31:24];
  endfunction

  function automatic eth_dma_pkg::axi_data_t ext_word(input logic [31:0] a);
    logic [31:0] base;
    base = {a[31:2], 2'b00};
    return {ext_byte(base + 3), ext_byte(base + 2), ext_byte(base + 1), ext_byte(base)};
  endfunction

  task automatic check_byte(input string name, input eth_dma_pkg::byte_t got,
                            input eth_dma_pkg::byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input eth_dma_pkg::bd_word_t got,
                            input eth_dma_pkg::bd_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_nbytes(input string name, input eth_dma_pkg::nbytes_t got,
                              input eth_dma_pkg::nbytes_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_burst(input string name, input eth_dma_pkg::burst_len_t got,
                             input eth_dma_pkg::burst_len_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  task automatic prepare_ring();
    eth_dma_pkg::frame_len_t len;
    logic                    rdy;
    logic                    wrap;
    logic [10:0]             low;
    for (int a = 0; a < 256; a++) begin
      desc_mem[a] = '0;
    end
    for (int n = 0; n < NUM_BD; n++) begin
      len  = $unsigned($random(seed)) % (MAX_LEN + 1);
      rdy  = (n == 0) || ($unsigned($random(seed)) % 5 != 0);
      wrap = (n == NUM_BD - 1);
      low  = $random(seed);
      // A few fixed corner cases among the random ones
      if (n == 1) len = MAX_LEN;
      if (n == 3) len = 0;
      if (n == 5) rdy = 1'b0;
      // Ready while tx_en_i is off, so only the enable holds it back
      if (n == TX_OFF_BD) rdy = 1'b1;
      ctrl[n] = {len, rdy, 1'($random(seed)), wrap, 1'($random(seed)),
                 1'($random(seed)), low};
      ptr[n]  = $random(seed);
      desc_mem[2 * n]     = ctrl[n];
      desc_mem[2 * n + 1] = ptr[n];
    end
  endtask

  task automatic check_burst_request();
    int rem;
    int chunk;
    rem = int'(ctrl[cur_n][eth_dma_pkg::BD_LEN_LSB +: 16]) - issued;
    if (rem <= 0) begin
      report_error("burst requested past the end of the frame");
    end else begin
      chunk = (rem > eth_dma_pkg::MAX_BURST_LEN) ? eth_dma_pkg::MAX_BURST_LEN : rem;
      check_word("araddr_o", araddr_o, ptr[cur_n] + 32'(issued));
      check_burst("arlen_o", arlen_o, eth_dma_pkg::burst_len_t'(chunk - 1));
      issued += chunk;
    end
  endtask

  task automatic check_handoff();
    int          len;
    logic [31:0] p;
    len  = ctrl[cur_n][eth_dma_pkg::BD_LEN_LSB +: 16];
    p    = ptr[cur_n];
    sent = 1'b1;
    if (issued != len) begin
      report_error("frame handed to the transmitter before all bytes were requested");
    end
    check_nbytes("tx_nbytes_o", tx_nbytes_o, eth_dma_pkg::nbytes_t'(8 + len));
    check_bit("crc_en_o", crc_en_o, ctrl[cur_n][eth_dma_pkg::BD_CRC_BIT]);
    for (int k = 0; k < len; k++) begin
      check_byte($sformatf("tx_buf[%0d]", 8 + k), tx_buf[8 + k], ext_byte(p + 32'(k)));
      // Stale bytes must not satisfy the next frame
      tx_buf[8 + k] = 'x;
    end
  endtask

  task automatic check_writeback();
    eth_dma_pkg::bd_word_t exp_word;
    exp_word = ctrl[cur_n];
    exp_word[eth_dma_pkg::BD_READY_BIT] = 1'b0;
    if (!sent) begin
      report_error("status written back before the frame was handed over");
    end
    check_word("bd_addr_o", 32'(bd_addr_o), 32'(2 * cur_n));
    check_word("bd_o", bd_o, exp_word);
    check_bit("tx_irq_o", tx_irq_o, ctrl[cur_n][eth_dma_pkg::BD_IRQ_BIT]);
    desc_mem[bd_addr_o] = bd_o;
    if (ctrl[cur_n][eth_dma_pkg::BD_WRAP_BIT] || cur_n == BD_LAST) begin
      cur_n = 0;
    end else begin
      cur_n++;
    end
    issued = 0;
    sent   = 1'b0;
    wb_count++;
  endtask

  // Outputs sampled mid-cycle, away from both edges
  always @(negedge clk_i) begin
    bd_addr_s = bd_addr_o;
    araddr_s  = araddr_o;
    arlen_s   = arlen_o;
    ar_acc    = arvalid_o && arready_i;
    r_acc     = rvalid_i && rready_o;
    send_s    = send_o;
    if (!arst_i) begin
      if (buf_wen_o) tx_buf[buf_addr_o] = buf_wdata_o;
      if (hold && (arvalid_o || send_o || bd_wen_o)) begin
        report_error("DMA activity on a descriptor it must not serve");
      end
      if (tx_irq_o && !bd_wen_o) report_error("interrupt raised outside a status writeback");
      if (ar_acc) check_burst_request();
      if (send_o && !sent) check_handoff();
      if (bd_wen_o) check_writeback();
    end
  end

  // Descriptor memory, AXI read slave and transmitter
  always @(posedge clk_i) begin
    #1;
    bd_i = desc_mem[bd_addr_s];
    if (r_acc) begin
      beat_addr  = beat_addr + 1;
      beats_left = beats_left - 1;
    end
    if (ar_acc) begin
      beat_addr  = araddr_s;
      beats_left = arlen_s + 1;
    end
    if (!(rvalid_i && !r_acc)) begin
      rvalid_i = (beats_left > 0) && ($unsigned($random(seed)) % 4 != 0);
      rdata_i  = rvalid_i ? ext_word(beat_addr) : $random(seed);
      rlast_i  = rvalid_i && (beats_left == 1);
    end
    arready_i = ($unsigned($random(seed)) % 3 != 0);
    case (tx_phase)
      0: begin
        if (send_s) begin
          tx_cnt   = $unsigned($random(seed)) % 5;
          tx_phase = 1;
        end
      end
      1: begin
        if (tx_cnt == 0) begin
          tx_ready_i = 1'b0;
          tx_cnt     = 2 + $unsigned($random(seed)) % 5;
          tx_phase   = 2;
        end else begin
          tx_cnt = tx_cnt - 1;
        end
      end
      default: begin
        // Busy on the wire until send_o is gone
        if (!send_s) tx_cnt = tx_cnt - 1;
        if (tx_cnt == 0) begin
          tx_ready_i = 1'b1;
          tx_phase   = 0;
        end
      end
    endcase
  end

  task automatic pause_tx_enable();
    hold    = 1'b1;
    tx_en_i = 1'b0;
    repeat (50) @(posedge clk_i);
    #1;
    tx_en_i = 1'b1;
    hold    = 1'b0;
  endtask

  // Software hands a stalled descriptor over later
  task automatic release_late_descriptor(input int n);
    hold = 1'b1;
    repeat (60) @(negedge clk_i);
    #1;
    desc_mem[2 * n][eth_dma_pkg::BD_READY_BIT] = 1'b1;
    ctrl[n][eth_dma_pkg::BD_READY_BIT]         = 1'b1;
    hold = 1'b0;
  endtask

  initial begin
    arst_i     = 1'b1;
    tx_en_i    = 1'b0;
    bd_i       = '0;
    arready_i  = 1'b0;
    rdata_i    = '0;
    rvalid_i   = 1'b0;
    rlast_i    = 1'b0;
    tx_ready_i = 1'b1;
    prepare_ring();
    repeat (8) @(posedge clk_i);
    #1;
    arst_i  = 1'b0;
    tx_en_i = 1'b1;
    repeat (12) @(negedge clk_i);
    for (int a = 0; a < 8; a++) begin
      check_byte($sformatf("tx_buf[%0d]", a), tx_buf[a],
                 (a < eth_dma_pkg::PREAMBLE_LEN) ? 8'h55 : 8'hD5);
    end
    for (int i = 0; i < NUM_BD; i++) begin
      wait (wb_count == i);
      @(posedge clk_i);
      #1;
      if (i == TX_OFF_BD) pause_tx_enable();
      if (!ctrl[i][eth_dma_pkg::BD_READY_BIT]) release_late_descriptor(i);
    end
    wait (wb_count == NUM_BD);
    // After the wrap, descriptor 0 belongs to software again
    hold = 1'b1;
    repeat (40) @(negedge clk_i);
    check_word("bd_addr_o", 32'(bd_addr_o), 32'(0));
    // Bound assertion failures count as errors too
    errors = errors + DUT.sva_i.fail_cnt;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: only %0d of %0d descriptors written back", wb_count, NUM_BD);
    $display("Verification failed");
    $finish;
  end

endmodule

/* compile.f */
src/eth_dma_pkg.sv
src/tx_dma_if.sv
src/tx_bd_fetch.sv
src/tx_frame_copy.sv
src/tx_frame_launch.sv
src/eth_tx_dma.sv
verification/eth_tx_dma_sva.sv
verification/eth_tx_dma_tb.sv
